// ==== design/motor_pkg.sv ====
// Numeric widths and constants shared by the motor positioning datapath
// Angles live on a 4096-point circle, ratios are 8-bit PWM high times
package motor_pkg;

    // Encoder and target angle width, one full turn is 2**angle_w points
    parameter int angle_w = 12;

    parameter int ratio_w = 8;          // PWM high time out of 255
    parameter int step_w = 4;           // Profile step index
    parameter int profile_depth = 16;   // Entries in the packed accel profile

    // Dwell counter, wide enough for a 4-bit mantissa shifted by up to 15
    parameter int dwell_w = 24;

    // A move whose distance is at or below this counts as done
    parameter int target_tolerance = 5;

    typedef logic [angle_w-1:0] angle_t;
    typedef logic [ratio_w-1:0] ratio_t;
    typedef logic [step_w-1:0]  step_t;

endpackage

// ==== design/ctrl_pkg.sv ====
// Control encodings for the motion sequencer
// State and ratio source enums used between the FSM and the ratio table
package ctrl_pkg;

    // Motion phases of one move
    typedef enum logic [2:0] {
        st_idle,        // Waiting for a move request
        st_calc,        // Distance and direction being computed
        st_accel,       // Walking up the profile
        st_cruise,      // Fixed power
        st_decel,       // Walking back down the profile
        st_shutdown     // Zero ratio, waiting for the PWM to take it
    } motion_state_t;

    // Which value the ratio register loads
    typedef enum logic [1:0] {
        src_zero,       // Motor off
        src_profile,    // Profile entry plus offset
        src_cruise      // Cruise power input
    } ratio_src_t;

endpackage

// ==== design/angle_delta.sv ====
// Shortest circular distance and direction from the current to the target angle
// Results are registered every cycle; calc_valid qualifies them for the FSM
`timescale 1ns/1ps

module angle_delta (
    input  logic              clock,
    input  logic              reset_n,
    input  logic              calc_enable,     // Held high by the FSM while it waits
    input  motor_pkg::angle_t target_angle,
    input  motor_pkg::angle_t current_angle,
    output motor_pkg::angle_t delta_angle,     // Distance along the shorter path
    output logic              dir_shortest,    // 1 = forward, 0 = reverse
    output logic              calc_valid
);

    // Beyond half a turn the reverse path is shorter
    localparam motor_pkg::angle_t half_turn = motor_pkg::angle_t'(1 << (motor_pkg::angle_w - 1));

    motor_pkg::angle_t fwd_diff;    // Forward difference modulo a full turn
    logic              enable_q;    // calc_enable one cycle late

    assign fwd_diff = target_angle - current_angle;

    // Distance and direction track the inputs with one cycle of latency
    always_ff @(posedge clock) begin
        if (fwd_diff > half_turn) begin
            delta_angle  <= motor_pkg::angle_t'(0) - fwd_diff; // Full turn minus forward
            dir_shortest <= 1'b0;
        end else begin
            delta_angle  <= fwd_diff;
            dir_shortest <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            enable_q <= 1'b0;
        end else begin
            enable_q <= calc_enable;
        end
    end

    // Registered result is fresh one cycle after enable and drops with it
    assign calc_valid = calc_enable & enable_q;

endmodule

// ==== design/step_timer.sv ====
// Counts PWM confirmations and ticks once each profile step has dwelt long enough
// The dwell target is a 4-bit mantissa shifted left by a 4-bit exponent
`timescale 1ns/1ps

module step_timer (
    input  logic       clock,
    input  logic       reset_n,
    input  logic       pwm_done,       // Level from the PWM, rises once a ratio is applied
    input  logic       dwell_run,      // Low clears the count
    input  logic [7:0] delay_target,   // [7:4] mantissa, [3:0] shift
    output logic       step_tick
);

    logic                          done_sync;     // Synchroniser stage
    logic                          done_prev;     // Previous synced level
    logic                          done_rise;     // One-cycle pulse per pwm_done rise
    logic [motor_pkg::dwell_w-1:0] dwell_count;
    logic [motor_pkg::dwell_w-1:0] dwell_target;

    assign dwell_target = {{(motor_pkg::dwell_w - 4){1'b0}}, delay_target[7:4]}
                          << delay_target[3:0];

    // Rise pulse lands two cycles after pwm_done goes high
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            done_sync <= 1'b0;
            done_prev <= 1'b0;
            done_rise <= 1'b0;
        end else begin
            done_sync <= pwm_done;
            done_prev <= done_sync;
            done_rise <= done_sync & ~done_prev;   // Ignores a level left high from before
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            dwell_count <= '0;
        end else if (!dwell_run) begin
            dwell_count <= '0;                       // Phase change restarts the dwell
        end else if (done_rise) begin
            if (dwell_count == dwell_target)
                dwell_count <= '0;                   // Step complete
            else
                dwell_count <= dwell_count + 1'b1;
        end
    end

    // Step lasts dwell_target + 1 confirmations
    assign step_tick = dwell_run & done_rise & (dwell_count == dwell_target);

endmodule

// ==== design/profile_table.sv ====
// PWM ratio register fed from the packed acceleration profile
// Each entry gets the common offset added; the FSM picks zero, profile or cruise
`timescale 1ns/1ps

module profile_table #(
    parameter int profile_depth = 16
) (
    input  logic                                       clock,
    input  logic                                       reset_n,
    input  logic [profile_depth*motor_pkg::ratio_w-1:0] pwm_profile,   // Entry 0 in the low byte
    input  motor_pkg::ratio_t                          profile_offset,
    input  motor_pkg::ratio_t                          cruise_power,
    input  ctrl_pkg::ratio_src_t                       ratio_src,
    input  motor_pkg::step_t                           step_index,
    output motor_pkg::ratio_t                          pwm_ratio
);

    motor_pkg::ratio_t profile_entry [profile_depth];   // Offset already applied
    motor_pkg::ratio_t ratio_next;

    // Unpack and offset every entry, sum wraps at 8 bits
    for (genvar i = 0; i < profile_depth; i++) begin : g_entry
        assign profile_entry[i] = pwm_profile[i*motor_pkg::ratio_w +: motor_pkg::ratio_w]
                                  + profile_offset;
    end

    always_comb begin
        case (ratio_src)
            ctrl_pkg::src_profile: ratio_next = profile_entry[step_index];
            ctrl_pkg::src_cruise:  ratio_next = cruise_power;
            default:               ratio_next = '0;      // Idle, calc and shutdown
        endcase
    end

    // New ratio one cycle after a source or step change
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            pwm_ratio <= '0;
        end else begin
            pwm_ratio <= ratio_next;
        end
    end

endmodule

// ==== design/motion_control.sv ====
// Move sequencer for the wheel motor
// Runs calc, accel, cruise, decel and shutdown for each angle_update request
// Steps advance only on step_tick from the dwell timer
`timescale 1ns/1ps

module motion_control #(
    parameter int decel_distance = 10,
    parameter int profile_depth  = 16
) (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 angle_update,    // Strobe, starts a move
    input  logic                 abort_angle,     // Level
    input  motor_pkg::angle_t    delta_angle,
    input  logic                 dir_shortest,
    input  logic                 calc_valid,
    input  logic                 step_tick,
    output logic                 calc_enable,
    output logic                 dwell_run,
    output ctrl_pkg::ratio_src_t ratio_src,
    output motor_pkg::step_t     step_index,
    output logic                 pwm_direction,
    output logic                 pwm_update,
    output logic                 pwm_enable,
    output logic                 angle_done
);

    localparam motor_pkg::step_t last_step = motor_pkg::step_t'(profile_depth - 1);
    localparam motor_pkg::angle_t tolerance = motor_pkg::angle_t'(motor_pkg::target_tolerance);
    localparam motor_pkg::angle_t decel_point = motor_pkg::angle_t'(decel_distance);

    ctrl_pkg::motion_state_t state, state_next;
    logic                    move_active;   // Accel through shutdown
    logic                    dwell_phase;   // Phases paced by the dwell timer

    always_comb begin
        state_next = state;
        case (state)
            ctrl_pkg::st_idle: begin
                if (angle_update)
                    state_next = ctrl_pkg::st_calc;
            end
            ctrl_pkg::st_calc: begin
                if (abort_angle)
                    state_next = ctrl_pkg::st_idle;
                else if (calc_valid)
                    state_next = (delta_angle <= tolerance) ? ctrl_pkg::st_idle  // Already there
                                                            : ctrl_pkg::st_accel;
            end
            ctrl_pkg::st_accel: begin
                if (abort_angle)
                    state_next = ctrl_pkg::st_decel;        // Ramp down from current step
                else if (step_tick && step_index == last_step)
                    state_next = ctrl_pkg::st_cruise;
            end
            ctrl_pkg::st_cruise: begin
                if (delta_angle < decel_point)
                    state_next = ctrl_pkg::st_decel;
            end
            ctrl_pkg::st_decel: begin
                if (delta_angle < tolerance)
                    state_next = ctrl_pkg::st_shutdown;
            end
            ctrl_pkg::st_shutdown: begin
                if (step_tick)
                    state_next = ctrl_pkg::st_idle;        // Zero ratio confirmed
            end
            default: state_next = ctrl_pkg::st_idle;
        endcase
    end

    assign dwell_phase = (state == ctrl_pkg::st_accel) || (state == ctrl_pkg::st_decel)
                         || (state == ctrl_pkg::st_shutdown);

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state         <= ctrl_pkg::st_idle;
            step_index    <= '0;
            pwm_direction <= 1'b0;
            move_active   <= 1'b0;
            angle_done    <= 1'b0;
            dwell_run     <= 1'b0;
        end else begin
            state       <= state_next;
            move_active <= (state_next != ctrl_pkg::st_idle) && (state_next != ctrl_pkg::st_calc);
            angle_done  <= (state == ctrl_pkg::st_shutdown) && (state_next == ctrl_pkg::st_idle);
            // Drops for one cycle on every phase change so each phase dwells from zero
            dwell_run   <= dwell_phase && (state_next == state);

            if (state == ctrl_pkg::st_calc && state_next == ctrl_pkg::st_accel)
                pwm_direction <= dir_shortest;         // Fixed for the whole move

            case (state)
                ctrl_pkg::st_idle, ctrl_pkg::st_calc: step_index <= '0;
                ctrl_pkg::st_accel: begin
                    if (!abort_angle && step_tick && step_index != last_step)
                        step_index <= step_index + 1'b1;
                end
                ctrl_pkg::st_cruise: step_index <= last_step;  // Decel starts at the top
                ctrl_pkg::st_decel: begin
                    if (step_tick && step_index != '0)
                        step_index <= step_index - 1'b1;
                end
                default: step_index <= step_index;
            endcase
        end
    end

    assign calc_enable = (state == ctrl_pkg::st_calc);
    assign pwm_update  = move_active;
    assign pwm_enable  = move_active;

    always_comb begin
        case (state)
            ctrl_pkg::st_accel, ctrl_pkg::st_decel: ratio_src = ctrl_pkg::src_profile;
            ctrl_pkg::st_cruise:                    ratio_src = ctrl_pkg::src_cruise;
            default:                                ratio_src = ctrl_pkg::src_zero;
        endcase
    end

endmodule

// ==== design/angle_to_pwm.sv ====
// Angle to PWM positioning controller, top level
// Takes a target angle and encoder angle, drives a PWM ratio and direction
// through an accel, cruise and decel profile, then pulses angle_done
`timescale 1ns/1ps

module angle_to_pwm #(
    parameter int decel_distance = 10,                      // Distance where cruise ends
    parameter int profile_depth  = motor_pkg::profile_depth
) (
    input  logic                                        clock,
    input  logic                                        reset_n,
    input  motor_pkg::angle_t                           target_angle,
    input  motor_pkg::angle_t                           current_angle,   // From the encoder
    input  logic                                        pwm_done,
    input  logic                                        angle_update,
    input  logic                                        abort_angle,
    input  logic [7:0]                                  delay_target,    // Dwell per step
    input  motor_pkg::ratio_t                           profile_offset,
    input  motor_pkg::ratio_t                           cruise_power,
    input  logic [profile_depth*motor_pkg::ratio_w-1:0] pwm_profile,
    output logic                                        angle_done,
    output logic                                        pwm_enable,
    output logic                                        pwm_update,
    output motor_pkg::ratio_t                           pwm_ratio,
    output logic                                        pwm_direction
);

    logic                 calc_enable;
    logic                 dwell_run;
    ctrl_pkg::ratio_src_t ratio_src;
    motor_pkg::step_t     step_index;
    motor_pkg::angle_t    delta_angle;
    logic                 dir_shortest;
    logic                 calc_valid;
    logic                 step_tick;

    motion_control #(
        .decel_distance (decel_distance),
        .profile_depth  (profile_depth)
    ) u_motion_control (
        .clock          (clock),
        .reset_n        (reset_n),
        .angle_update   (angle_update),
        .abort_angle    (abort_angle),
        .delta_angle    (delta_angle),
        .dir_shortest   (dir_shortest),
        .calc_valid     (calc_valid),
        .step_tick      (step_tick),
        .calc_enable    (calc_enable),
        .dwell_run      (dwell_run),
        .ratio_src      (ratio_src),
        .step_index     (step_index),
        .pwm_direction  (pwm_direction),
        .pwm_update     (pwm_update),
        .pwm_enable     (pwm_enable),
        .angle_done     (angle_done)
    );

    angle_delta u_angle_delta (
        .clock          (clock),
        .reset_n        (reset_n),
        .calc_enable    (calc_enable),
        .target_angle   (target_angle),
        .current_angle  (current_angle),
        .delta_angle    (delta_angle),
        .dir_shortest   (dir_shortest),
        .calc_valid     (calc_valid)
    );

    step_timer u_step_timer (
        .clock          (clock),
        .reset_n        (reset_n),
        .pwm_done       (pwm_done),
        .dwell_run      (dwell_run),
        .delay_target   (delay_target),
        .step_tick      (step_tick)
    );

    profile_table #(
        .profile_depth  (profile_depth)
    ) u_profile_table (
        .clock          (clock),
        .reset_n        (reset_n),
        .pwm_profile    (pwm_profile),
        .profile_offset (profile_offset),
        .cruise_power   (cruise_power),
        .ratio_src      (ratio_src),
        .step_index     (step_index),
        .pwm_ratio      (pwm_ratio)
    );

endmodule

// ==== verif/tb_angle_to_pwm.sv ====
// Directed testbench for the angle to PWM positioning controller
// A PWM responder pulses pwm_done after each ratio change and a motor model
// steps the encoder one point per confirmation while the ratio is nonzero
`timescale 1ns/1ps

module tb_angle_to_pwm;

    localparam int clk_period   = 40;
    localparam int budget_near  = 300;     // Cycle budgets per test
    localparam int budget_dir   = 1000;
    localparam int budget_accel = 1500;
    localparam int budget_done  = 400;
    localparam int budget_abort = 1500;
    localparam int budget_total = 20 + budget_near + budget_dir + budget_accel
                                  + budget_done + budget_abort;

    logic              clock;
    logic              reset_n;
    motor_pkg::angle_t target_angle;
    motor_pkg::angle_t current_angle = '0;  // Owned by the motor model
    logic              pwm_done = 1'b0;     // Owned by the PWM responder
    logic              angle_update;
    logic              abort_angle;
    logic [7:0]        delay_target;
    motor_pkg::ratio_t profile_offset;
    motor_pkg::ratio_t cruise_power;
    logic [16*8-1:0]   pwm_profile;
    logic              angle_done;
    logic              pwm_enable;
    logic              pwm_update;
    motor_pkg::ratio_t pwm_ratio;
    logic              pwm_direction;

    logic [31:0]       rng_state = 32'h3699_399b;
    motor_pkg::ratio_t last_ratio = '0;     // Responder's copy of the ratio
    int                resp_count = 0;      // Cycles since the last ratio change
    int                rise_count = 0;      // Total pwm_done pulses
    logic              jump_req = 1'b0;     // Encoder jump request to the model
    motor_pkg::angle_t jump_angle = '0;
    motor_pkg::ratio_t seen_ratio = '0;     // Last ratio seen by the tests
    int                mark_rises = 0;      // rise_count at that change

    angle_to_pwm #(
        .decel_distance (10),
        .profile_depth  (16)
    ) DUT (
        .clock          (clock),
        .reset_n        (reset_n),
        .target_angle   (target_angle),
        .current_angle  (current_angle),
        .pwm_done       (pwm_done),
        .angle_update   (angle_update),
        .abort_angle    (abort_angle),
        .delay_target   (delay_target),
        .profile_offset (profile_offset),
        .cruise_power   (cruise_power),
        .pwm_profile    (pwm_profile),
        .angle_done     (angle_done),
        .pwm_enable     (pwm_enable),
        .pwm_update     (pwm_update),
        .pwm_ratio      (pwm_ratio),
        .pwm_direction  (pwm_direction)
    );

    initial begin
        clock = 1'b0;
        forever #(clk_period / 2) clock = ~clock;
    end

    initial begin
        #(budget_total * clk_period);
        $display("Timeout: tests did not finish within %0d cycles", budget_total);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    // PWM responder and motor model share one process so pulse and move stay ordered
    always @(posedge clock) begin
        #2;
        if (jump_req) begin
            current_angle = jump_angle;     // Encoder set by a test
            jump_req = 1'b0;
        end
        if (!pwm_enable || pwm_ratio != last_ratio)
            resp_count = 0;
        else
            resp_count = resp_count + 1;
        last_ratio = pwm_ratio;
        pwm_done = pwm_enable && resp_count % 8 == 3;   // 3 cycles after a change, then every 8
        if (pwm_done) begin
            rise_count = rise_count + 1;
            if (pwm_ratio != '0 && current_angle != target_angle)
                current_angle = pwm_direction ? current_angle + 12'd1 : current_angle - 12'd1;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic motor_pkg::ratio_t expected_entry(input int idx);
        return pwm_profile[idx*8 +: 8] + profile_offset;   // Wraps at 8 bits
    endfunction

    // Forward wins ties at half a turn
    function automatic logic shortest_forward(input motor_pkg::angle_t tgt,
                                              input motor_pkg::angle_t cur);
        motor_pkg::angle_t fwd;
        fwd = tgt - cur;
        return fwd <= 12'd2048;
    endfunction

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("** Error at time %0t: %s = %0d, expected %0d", $time, name, actual,
                     expected);
            $display("STATUS: FAIL");
            $fatal(1, "check failed");
        end
    endtask

    task automatic make_profile();
        motor_pkg::ratio_t prev;
        motor_pkg::ratio_t b;
        rng_state = xorshift32(rng_state);
        profile_offset = rng_state[7:0];
        delay_target = 8'h11;               // Mantissa 1 shifted by 1 gives three rises a step
        prev = '0;
        for (int i = 0; i < 16; i++) begin
            rng_state = xorshift32(rng_state);
            b = rng_state[15:8];
            // Neighbours differ and none is zero so each step shows as a change
            while (motor_pkg::ratio_t'(b + profile_offset) == 8'd0
                   || motor_pkg::ratio_t'(b + profile_offset) == prev)
                b = b + 8'd1;
            pwm_profile[i*8 +: 8] = b;
            prev = b + profile_offset;
        end
        rng_state = xorshift32(rng_state);
        cruise_power = rng_state[7:0];
        while (cruise_power == 8'd0 || cruise_power == prev)
            cruise_power = cruise_power + 8'd1;
    endtask

    task automatic start_move(input motor_pkg::angle_t cur, input motor_pkg::angle_t tgt);
        @(negedge clock);
        jump_angle = cur;
        jump_req = 1'b1;
        @(posedge clock);
        #2;
        target_angle = tgt;
        angle_update = 1'b1;                // One-cycle strobe
        seen_ratio = '0;
        mark_rises = rise_count;
        @(posedge clock);
        #2;
        angle_update = 1'b0;
    endtask

    task automatic wait_move_start();
        @(negedge clock);
        while (!pwm_update)
            @(negedge clock);
    endtask

    task automatic wait_idle();
        @(negedge clock);
        while (pwm_enable)
            @(negedge clock);
    endtask

    // Next distinct ratio and the pwm_done rises seen while the old one was held
    task automatic next_ratio(output motor_pkg::ratio_t value, output int rises);
        @(negedge clock);
        while (pwm_ratio == seen_ratio) begin
            check_value("angle_done", angle_done, 0);   // Never during a move
            @(negedge clock);
        end
        rises = rise_count - mark_rises;
        mark_rises = rise_count;
        seen_ratio = pwm_ratio;
        value = pwm_ratio;
    endtask

    // Steps down from top_step, then zero, then a single done pulse
    task automatic check_ramp_down(input int top_step);
        motor_pkg::ratio_t r;
        int                rises;
        int                step;
        step = top_step;
        next_ratio(r, rises);
        check_value("pwm_ratio", r, expected_entry(step));   // First change is the top step
        while (r != '0) begin
            step = step - 1;
            next_ratio(r, rises);
            if (r != '0)
                check_value("pwm_ratio", r, (step >= 0) ? expected_entry(step) : 0);
        end
        @(negedge clock);
        while (!angle_done)
            @(negedge clock);
        check_value("pwm_enable", pwm_enable, 0);
        check_value("pwm_update", pwm_update, 0);
        repeat (8) begin
            @(negedge clock);
            check_value("angle_done", angle_done, 0);  // Pulse lasts one cycle and comes once
            check_value("pwm_enable", pwm_enable, 0);
        end
    endtask

    task automatic test_near_target();
        motor_pkg::angle_t base;
        motor_pkg::angle_t d;
        for (int n = 0; n < 6; n++) begin
            rng_state = xorshift32(rng_state);
            base = rng_state[11:0];
            d = motor_pkg::angle_t'(n);     // Distances 0 to 5
            start_move(base, rng_state[12] ? base + d : base - d);
            repeat (12) begin
                @(negedge clock);
                check_value("pwm_enable", pwm_enable, 0);
                check_value("pwm_update", pwm_update, 0);
                check_value("angle_done", angle_done, 0);
                check_value("pwm_ratio", pwm_ratio, 0);
            end
        end
    endtask

    task automatic test_direction();
        motor_pkg::angle_t cur;
        motor_pkg::angle_t tgt;
        motor_pkg::angle_t fwd;
        for (int n = 0; n < 7; n++) begin
            rng_state = xorshift32(rng_state);
            cur = rng_state[11:0];
            tgt = (n == 0) ? cur + 12'd2048 : rng_state[27:16];   // First pair is a tie
            fwd = tgt - cur;
            if (fwd <= 12'd5 || fwd >= 12'd4091)
                tgt = tgt + 12'd100;        // Keep clear of the tolerance
            start_move(cur, tgt);
            wait_move_start();
            check_value("pwm_direction", pwm_direction, shortest_forward(tgt, cur));
            @(negedge clock);
            jump_angle = tgt;               // Put the motor on target and wind down
            jump_req = 1'b1;
            @(posedge clock);
            #2;
            abort_angle = 1'b1;
            wait_idle();
            @(posedge clock);
            #2;
            abort_angle = 1'b0;
        end
    endtask

    task automatic test_acceleration();
        motor_pkg::ratio_t r;
        motor_pkg::angle_t cur;
        int                rises;
        int                dwell;
        dwell = (int'(delay_target[7:4]) << delay_target[3:0]) + 1;
        rng_state = xorshift32(rng_state);
        cur = rng_state[11:0];
        start_move(cur, cur - 12'd120);     // Reverse move far enough to reach cruise
        wait_move_start();
        for (int i = 0; i <= 16; i++) begin
            next_ratio(r, rises);
            check_value("pwm_ratio", r, (i < 16) ? expected_entry(i) : cruise_power);
            if (i > 0)
                check_value("pwm_done rises per step", rises, dwell);
        end
    endtask

    task automatic test_completion();
        check_ramp_down(15);                // Continues the move from cruise
    endtask

    task automatic test_abort();
        motor_pkg::ratio_t r;
        motor_pkg::angle_t cur;
        int                rises;
        rng_state = xorshift32(rng_state);
        cur = rng_state[11:0];
        start_move(cur, cur + 12'd80);
        wait_move_start();
        for (int i = 0; i <= 5; i++) begin
            next_ratio(r, rises);
            check_value("pwm_ratio", r, expected_entry(i));
        end
        @(posedge clock);
        #2;
        abort_angle = 1'b1;                 // Mid accel at step 5
        check_ramp_down(4);
        @(posedge clock);
        #2;
        abort_angle = 1'b0;
    endtask

    initial begin
        reset_n = 1'b0;
        angle_update = 1'b0;
        abort_angle = 1'b0;
        target_angle = '0;
        make_profile();
        repeat (10) @(posedge clock);
        #2;
        reset_n = 1'b1;
        test_near_target();
        test_direction();
        test_acceleration();
        test_completion();
        test_abort();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== angle_to_pwm.f ====
design/motor_pkg.sv
design/ctrl_pkg.sv
design/angle_delta.sv
design/step_timer.sv
design/profile_table.sv
design/motion_control.sv
design/angle_to_pwm.sv
verif/tb_angle_to_pwm.sv

// ==== Makefile ====
# Verilator lint and simulation for the angle to PWM controller

VERILATOR  ?= verilator
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal
TOP        := tb_angle_to_pwm
RTL_TOP    := angle_to_pwm
FILELIST   := angle_to_pwm.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
